//--- aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire cpuPkg::word_t constData,
	input wire logic yIn,
	input wire logic zIn,
	input wire logic cOut,
	input wire logic incPc,
	input wire cpuPkg::aluOp_t aluOp,
	output cpuPkg::word_t zLowData,
	output cpuPkg::word_t zHighData,
	output cpuPkg::word_t aluLow
);

	cpuPkg::word_t yReg;
	cpuPkg::word_t opA;
	cpuPkg::word_t opB;
	cpuPkg::aluOp_t effOp;
	cpuPkg::dword_t result;
	logic [4:0] shamt;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			yReg <= '0;
		end else if (yIn) begin
			yReg <= bus;
		end
	end

	assign opA = incPc ? 32'd1 : yReg;
	assign opB = cOut ? constData : bus;
	assign effOp = incPc ? cpuPkg::opAdd : aluOp; // increment is a plain add
	assign shamt = opB[4:0];

	always_comb begin
		result = '0;
		case (effOp)
			cpuPkg::opAdd: result[31:0] = opA + opB;
			cpuPkg::opSub: result[31:0] = opA - opB;
			cpuPkg::opAnd: result[31:0] = opA & opB;
			cpuPkg::opOr: result[31:0] = opA | opB;
			cpuPkg::opNeg: result[31:0] = -opB; // unary ops take B
			cpuPkg::opNot: result[31:0] = ~opB;
			cpuPkg::opShr: result[31:0] = opA >> shamt;
			cpuPkg::opShra: result[31:0] = $signed(opA) >>> shamt;
			cpuPkg::opShl: result[31:0] = opA << shamt;
			cpuPkg::opRor: result[31:0] = (opA >> shamt) | (opA << (6'd32 - shamt));
			cpuPkg::opRol: result[31:0] = (opA << shamt) | (opA >> (6'd32 - shamt));
			cpuPkg::opMul: result = $signed(opA) * $signed(opB); // full 64-bit product
			default: result = '0;
		endcase
	end

	assign aluLow = result[31:0];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			zLowData <= '0;
			zHighData <= '0;
		end else if (zIn) begin
			zLowData <= result[31:0];
			zHighData <= result[63:32];
		end
	end

	// the sequencer must pick a function whenever it latches z
	aZinOp: assert property (@(posedge Clock) disable iff (!rstN) zIn |-> aluOp != cpuPkg::opNone)
		else $error("aluUnit: zIn with no alu operation");

endmodule

`default_nettype wire

//--- build.f
cpuPkg.sv
busMux.sv
regFile.sv
specialRegs.sv
aluUnit.sv
memUnit.sv
conFf.sv
ioPorts.sv
dataPath.sv
tbDataPath.sv

//--- busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
	input wire logic Clock, // only for the one-hot check
	input wire logic rstN,
	input wire logic pcOut,
	input wire logic zLowOut,
	input wire logic zHighOut,
	input wire logic hiOut,
	input wire logic loOut,
	input wire logic mdrOut,
	input wire logic inPortOut,
	input wire logic regOut,
	input wire cpuPkg::word_t pcData,
	input wire cpuPkg::word_t zLowData,
	input wire cpuPkg::word_t zHighData,
	input wire cpuPkg::word_t hiData,
	input wire cpuPkg::word_t loData,
	input wire cpuPkg::word_t mdrData,
	input wire cpuPkg::word_t inPortData,
	input wire cpuPkg::word_t regData,
	output cpuPkg::word_t bus
);

	logic [7:0] outSel;

	assign outSel = {pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut, inPortOut, regOut};

	always_comb begin
		unique case (outSel)
			8'b1000_0000: bus = pcData;
			8'b0100_0000: bus = zLowData;
			8'b0010_0000: bus = zHighData;
			8'b0001_0000: bus = hiData;
			8'b0000_1000: bus = loData;
			8'b0000_0100: bus = mdrData;
			8'b0000_0010: bus = inPortData;
			8'b0000_0001: bus = regData;
			default: bus = '0; // idle bus reads zero
		endcase
	end

	// two drivers in one cycle would corrupt every destination loaded that cycle
	aOneSource: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(outSel))
		else $error("busMux: more than one out strobe %b", outSel);

endmodule

`default_nettype wire

//--- conFf.sv
`timescale 1ns/1ps
`default_nettype none

module conFf (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire cpuPkg::word_t ir,
	input wire logic conIn,
	output logic branchOut
);

	cpuPkg::cond_t cond;
	logic taken;

	assign cond = cpuPkg::cond_t'(ir[20:19]);

	always_comb begin
		case (cond)
			cpuPkg::condZero: taken = (bus == '0);
			cpuPkg::condNonZero: taken = (bus != '0);
			cpuPkg::condPos: taken = ~bus[31]; // zero counts as positive
			default: taken = bus[31];
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			branchOut <= 1'b0;
		end else if (conIn) begin
			branchOut <= taken;
		end
	end

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t; // bus and register word
	typedef logic [63:0] dword_t; // full alu result before the z split
	typedef logic [3:0] regIdx_t; // general register number

	typedef enum logic [3:0] {
		opNone = 4'd0,
		opAdd = 4'd1,
		opSub = 4'd2,
		opAnd = 4'd3,
		opOr = 4'd4,
		opNeg = 4'd5,
		opNot = 4'd6,
		opShr = 4'd7,
		opShra = 4'd8,
		opShl = 4'd9,
		opRor = 4'd10,
		opRol = 4'd11,
		opMul = 4'd12
	} aluOp_t;

	// branch conditions, from ir bits 20:19
	typedef enum logic [1:0] {
		condZero = 2'd0,
		condNonZero = 2'd1,
		condPos = 2'd2,
		condNeg = 2'd3
	} cond_t;

	localparam int memDepth = 256; // ram words
	typedef logic [$clog2(memDepth)-1:0] memAddr_t; // low bits of mar

	localparam int constWidth = 19; // ir immediate field

endpackage

`default_nettype wire

//--- dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic pcOut,
	input wire logic zLowOut,
	input wire logic zHighOut,
	input wire logic hiOut,
	input wire logic loOut,
	input wire logic mdrOut,
	input wire logic inPortOut,
	input wire logic rOut,
	input wire logic baOut,
	input wire logic gra,
	input wire logic grb,
	input wire logic grc,
	input wire logic rIn,
	input wire logic pcIn,
	input wire logic irIn,
	input wire logic hiIn,
	input wire logic loIn,
	input wire logic incPc,
	input wire logic yIn,
	input wire logic zIn,
	input wire logic cOut,
	input wire logic marIn,
	input wire logic mdrIn,
	input wire logic read,
	input wire logic write,
	input wire logic conIn,
	input wire logic strobe,
	input wire logic outPortIn,
	input wire cpuPkg::aluOp_t aluOp,
	input wire cpuPkg::word_t inPortData,
	output cpuPkg::word_t outPort,
	output logic branchOut
);

	cpuPkg::word_t bus;
	cpuPkg::word_t pcData, ir, hiData, loData, constData;
	cpuPkg::word_t zLowData, zHighData, aluLow;
	cpuPkg::word_t mdrData, inPortReg, regData;
	logic regOut;

	busMux i_busMux (
		.Clock(Clock), .rstN(rstN),
		.pcOut(pcOut), .zLowOut(zLowOut), .zHighOut(zHighOut), .hiOut(hiOut),
		.loOut(loOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .regOut(regOut),
		.pcData(pcData), .zLowData(zLowData), .zHighData(zHighData), .hiData(hiData),
		.loData(loData), .mdrData(mdrData), .inPortData(inPortReg), .regData(regData),
		.bus(bus)
	);

	regFile i_regFile (
		.Clock(Clock), .rstN(rstN), .bus(bus), .ir(ir),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut), .baOut(baOut),
		.regData(regData), .regOut(regOut)
	);

	specialRegs i_specialRegs (
		.Clock(Clock), .rstN(rstN), .bus(bus),
		.pcIn(pcIn), .irIn(irIn), .hiIn(hiIn), .loIn(loIn),
		.aluResult(aluLow), .incPc(incPc),
		.pcData(pcData), .ir(ir), .hiData(hiData), .loData(loData), .constData(constData)
	);

	aluUnit i_aluUnit (
		.Clock(Clock), .rstN(rstN), .bus(bus), .constData(constData),
		.yIn(yIn), .zIn(zIn), .cOut(cOut), .incPc(incPc), .aluOp(aluOp),
		.zLowData(zLowData), .zHighData(zHighData), .aluLow(aluLow)
	);

	memUnit i_memUnit (
		.Clock(Clock), .rstN(rstN), .bus(bus),
		.marIn(marIn), .mdrIn(mdrIn), .read(read), .write(write),
		.mdrData(mdrData)
	);

	conFf i_conFf (
		.Clock(Clock), .rstN(rstN), .bus(bus), .ir(ir), .conIn(conIn),
		.branchOut(branchOut)
	);

	ioPorts i_ioPorts (
		.Clock(Clock), .rstN(rstN), .bus(bus), .inPortData(inPortData),
		.strobe(strobe), .outPortIn(outPortIn),
		.inPortReg(inPortReg), .outPort(outPort)
	);

endmodule

`default_nettype wire

//--- ioPorts.sv
`timescale 1ns/1ps
`default_nettype none

module ioPorts (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire cpuPkg::word_t inPortData,
	input wire logic strobe,
	input wire logic outPortIn,
	output cpuPkg::word_t inPortReg,
	output cpuPkg::word_t outPort
);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			inPortReg <= '0;
		end else if (strobe) begin
			inPortReg <= inPortData; // device side
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			outPort <= '0;
		end else if (outPortIn) begin
			outPort <= bus;
		end
	end

endmodule

`default_nettype wire

//--- memUnit.sv
`timescale 1ns/1ps
`default_nettype none

module memUnit (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire logic marIn,
	input wire logic mdrIn,
	input wire logic read,
	input wire logic write,
	output cpuPkg::word_t mdrData
);

	cpuPkg::word_t mar;
	cpuPkg::word_t ram [cpuPkg::memDepth];
	cpuPkg::memAddr_t addr;
	cpuPkg::word_t ramData;

	assign addr = cpuPkg::memAddr_t'(mar); // upper mar bits ignored
	assign ramData = ram[addr];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
			mdrData <= '0;
		end else begin
			if (marIn) mar <= bus;
			if (mdrIn) mdrData <= read ? ramData : bus;
		end
	end

	always_ff @(posedge Clock) begin
		if (write) begin
			ram[addr] <= bus;
		end
	end

	// a read-modify in one cycle would leave mdr stale
	aNoRdWr: assert property (@(posedge Clock) disable iff (!rstN) !(read && write))
		else $error("memUnit: read and write together");

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire cpuPkg::word_t ir,
	input wire logic gra,
	input wire logic grb,
	input wire logic grc,
	input wire logic rIn,
	input wire logic rOut,
	input wire logic baOut,
	output cpuPkg::word_t regData,
	output logic regOut
);

	cpuPkg::word_t regs [16];
	cpuPkg::regIdx_t regIdx;

	// select/encode from the ir register fields
	always_comb begin
		regIdx = '0;
		if (gra) begin
			regIdx = ir[26:23];
		end else if (grb) begin
			regIdx = ir[22:19];
		end else if (grc) begin
			regIdx = ir[18:15];
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[regIdx] <= bus;
		end
	end

	// base address mode makes r0 a hard zero
	always_comb begin
		if (baOut && regIdx == '0) begin
			regData = '0;
		end else begin
			regData = regs[regIdx];
		end
	end

	assign regOut = rOut | baOut;

	// a field select must be unambiguous for the whole transfer
	aOneField: assert property (@(posedge Clock) disable iff (!rstN) $onehot0({gra, grb, grc}))
		else $error("regFile: more than one of gra/grb/grc");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the datapath testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbDataPath \
	-f build.f -o simDataPath \
	&& ./obj_dir/simDataPath \
	|| { echo "build or simulation failed"; exit 1; }

//--- specialRegs.sv
`timescale 1ns/1ps
`default_nettype none

module specialRegs (
	input wire logic Clock,
	input wire logic rstN,
	input wire cpuPkg::word_t bus,
	input wire logic pcIn,
	input wire logic irIn,
	input wire logic hiIn,
	input wire logic loIn,
	input wire cpuPkg::word_t aluResult,
	input wire logic incPc,
	output cpuPkg::word_t pcData,
	output cpuPkg::word_t ir,
	output cpuPkg::word_t hiData,
	output cpuPkg::word_t loData,
	output cpuPkg::word_t constData
);

	localparam int extWidth = $bits(cpuPkg::word_t) - cpuPkg::constWidth;

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pcData <= '0;
		end else if (incPc) begin
			pcData <= aluResult; // pc + 1 from the alu
		end else if (pcIn) begin
			pcData <= bus;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			ir <= '0;
			hiData <= '0;
			loData <= '0;
		end else begin
			if (irIn) ir <= bus;
			if (hiIn) hiData <= bus;
			if (loIn) loData <= bus;
		end
	end

	// sign-extended immediate
	assign constData = {{extWidth{ir[cpuPkg::constWidth-1]}}, ir[cpuPkg::constWidth-1:0]};

endmodule

`default_nettype wire

//--- tbDataPath.sv
`timescale 1ns/1ps
`default_nettype none

module tbDataPath;

	// bus sources and destinations for one transfer cycle
	typedef enum {sNone, sPc, sZLow, sZHigh, sHi, sLo, sMdr, sInPort, sRa, sRb, sBase, sConst,
		sRam} src_t;
	typedef enum {dNone, dIr, dRa, dY, dZ, dHi, dLo, dMar, dMdr, dPc, dPcInc, dOut, dCon,
		dRam} dst_t;

	localparam int clkPeriod = 4;
	localparam int testCycles = 2500; // upper bound for all directed tests

	integer seed = 32'hd13;
	logic Clock, rstN;
	logic pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut, inPortOut, rOut, baOut;
	logic gra, grb, grc, rIn, pcIn, irIn, hiIn, loIn, incPc, yIn, zIn, cOut;
	logic marIn, mdrIn, read, write, conIn, strobe, outPortIn;
	cpuPkg::aluOp_t aluOp;
	cpuPkg::word_t inPortData, outPort;
	logic branchOut;

	dataPath i_dataPath (.*);

	initial begin
		Clock = 1'b0;
		forever #(clkPeriod / 2) Clock = ~Clock;
	end

	initial begin
		#(2 * testCycles * clkPeriod); // twice the test length
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "simulation timed out");
	end

	task automatic checkWord(string name, cpuPkg::word_t got, cpuPkg::word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "word mismatch on %s", name);
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "bit mismatch on %s", name);
		end
	endtask

	task automatic clearStrobes();
		{pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut, inPortOut, rOut, baOut} = 9'b0;
		{gra, grb, grc, rIn, pcIn, irIn, hiIn, loIn, incPc, yIn, zIn, cOut} = 12'b0;
		{marIn, mdrIn, read, write, conIn, strobe, outPortIn} = 7'b0;
		aluOp = cpuPkg::opNone;
	endtask

	// one cycle: strobes set after a falling edge, cleared after the next one
	task automatic xfer(input src_t src, input dst_t dst,
		input cpuPkg::aluOp_t op = cpuPkg::opNone);
		case (src)
			sPc: pcOut = 1'b1;
			sZLow: zLowOut = 1'b1;
			sZHigh: zHighOut = 1'b1;
			sHi: hiOut = 1'b1;
			sLo: loOut = 1'b1;
			sMdr: mdrOut = 1'b1;
			sInPort: inPortOut = 1'b1;
			sRa: {rOut, gra} = 2'b11;
			sRb: {rOut, grb} = 2'b11;
			sBase: {baOut, gra} = 2'b11;
			sConst: cOut = 1'b1; // bus idle, B from ir
			sRam: read = 1'b1;
			default: ;
		endcase
		case (dst)
			dIr: irIn = 1'b1;
			dRa: {gra, rIn} = 2'b11;
			dY: yIn = 1'b1;
			dZ: zIn = 1'b1;
			dHi: hiIn = 1'b1;
			dLo: loIn = 1'b1;
			dMar: marIn = 1'b1;
			dMdr: mdrIn = 1'b1;
			dPc: pcIn = 1'b1;
			dPcInc: incPc = 1'b1;
			dOut: outPortIn = 1'b1;
			dCon: conIn = 1'b1;
			dRam: write = 1'b1;
			default: ;
		endcase
		aluOp = op;
		@(negedge Clock);
		clearStrobes();
	endtask

	task automatic latchInput(cpuPkg::word_t value);
		inPortData = value;
		strobe = 1'b1;
		@(negedge Clock);
		clearStrobes();
	endtask

	function automatic cpuPkg::word_t fieldWord(cpuPkg::regIdx_t ra, cpuPkg::regIdx_t rb);
		cpuPkg::word_t w;
		w = '0;
		w[26:23] = ra; // gra field
		w[22:19] = rb;
		return w;
	endfunction

	task automatic loadIr(cpuPkg::word_t value);
		latchInput(value);
		xfer(sInPort, dIr);
	endtask

	task automatic loadReg(cpuPkg::regIdx_t idx, cpuPkg::word_t value);
		loadIr(fieldWord(idx, 4'd0));
		latchInput(value);
		xfer(sInPort, dRa);
	endtask

	task automatic readReg(cpuPkg::regIdx_t idx, cpuPkg::word_t exp);
		loadIr(fieldWord(idx, 4'd0));
		xfer(sRa, dOut);
		checkWord($sformatf("outPort(R%0d)", idx), outPort, exp);
	endtask

	function automatic cpuPkg::word_t aluModel(cpuPkg::aluOp_t op, cpuPkg::word_t a,
		cpuPkg::word_t b);
		int sh;
		logic [63:0] twice;
		logic [63:0] zeroHi;
		logic [63:0] signHi;
		logic [63:0] zeroLo;
		cpuPkg::word_t res;
		sh = int'(b[4:0]);
		twice = {a, a}; // a 32-bit window of this is a rotation
		zeroHi = {32'b0, a}; // windows for the plain shifts
		signHi = {{32{a[31]}}, a};
		zeroLo = {a, 32'b0};
		res = '0;
		case (op)
			cpuPkg::opAdd: res = a + b;
			cpuPkg::opSub: res = a - b;
			cpuPkg::opAnd: res = a & b;
			cpuPkg::opOr: res = a | b;
			cpuPkg::opNeg: res = ~b + 32'd1;
			cpuPkg::opNot: res = ~b;
			cpuPkg::opShr: res = zeroHi[sh +: 32];
			cpuPkg::opShra: res = signHi[sh +: 32];
			cpuPkg::opShl: res = zeroLo[(32 - sh) +: 32];
			cpuPkg::opRor: res = twice[sh +: 32];
			cpuPkg::opRol: res = twice[(32 - sh) +: 32];
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic regTransfer();
		cpuPkg::word_t vals [16];
		for (int i = 1; i < 16; i++) begin
			vals[i] = $random(seed);
			loadReg(cpuPkg::regIdx_t'(i), vals[i]);
		end
		for (int i = 1; i < 16; i++) begin
			readReg(cpuPkg::regIdx_t'(i), vals[i]);
		end
	endtask

	task automatic aluOps();
		cpuPkg::word_t a, b;
		cpuPkg::aluOp_t op;
		for (int k = int'(cpuPkg::opAdd); k <= int'(cpuPkg::opRol); k++) begin
			op = cpuPkg::aluOp_t'(k);
			a = $random(seed);
			b = $random(seed);
			loadReg(4'd2, a);
			loadReg(4'd3, b);
			loadIr(fieldWord(4'd2, 4'd3));
			xfer(sRa, dY);
			xfer(sRb, dZ, op);
			xfer(sZLow, dOut);
			checkWord($sformatf("outPort(%s)", op.name()), outPort, aluModel(op, a, b));
		end
	endtask

	task automatic signedMultiply();
		cpuPkg::word_t a, b;
		cpuPkg::dword_t prod;
		repeat (4) begin
			a = $random(seed);
			b = $random(seed);
			prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // signed product mod 2^64
			loadReg(4'd2, a);
			loadReg(4'd3, b);
			loadIr(fieldWord(4'd2, 4'd3));
			xfer(sRa, dY);
			xfer(sRb, dZ, cpuPkg::opMul);
			xfer(sZHigh, dHi);
			xfer(sZLow, dLo);
			xfer(sHi, dOut);
			checkWord("outPort(hi)", outPort, prod[63:32]);
			xfer(sLo, dOut);
			checkWord("outPort(lo)", outPort, prod[31:0]);
		end
	endtask

	task automatic storeWord(cpuPkg::word_t addr, cpuPkg::word_t data);
		loadReg(4'd1, addr);
		loadReg(4'd2, data);
		loadIr(fieldWord(4'd1, 4'd2));
		xfer(sRa, dMar);
		xfer(sRb, dMdr);
		xfer(sMdr, dRam);
	endtask

	task automatic fetchWord(cpuPkg::word_t addr, cpuPkg::word_t exp);
		loadReg(4'd1, addr);
		loadIr(fieldWord(4'd1, 4'd0));
		xfer(sRa, dMar);
		xfer(sRam, dMdr);
		xfer(sMdr, dOut);
		checkWord("outPort(mem)", outPort, exp);
	endtask

	task automatic memoryAccess();
		cpuPkg::word_t addrA, addrB, dataA, dataB;
		addrA = $random(seed) & 32'hff;
		addrB = addrA ^ 32'h80; // other half of the ram
		dataA = $random(seed);
		dataB = $random(seed);
		storeWord(addrA, dataA);
		storeWord(addrB, dataB);
		fetchWord(addrA, dataA);
		fetchWord(addrB, dataB);
	endtask

	task automatic pcAndConst();
		cpuPkg::word_t start, y, irw;
		int cVal;
		start = $random(seed);
		latchInput(start);
		xfer(sInPort, dPc);
		xfer(sPc, dPcInc);
		xfer(sPc, dOut);
		checkWord("outPort(pc)", outPort, start + 32'd1);
		cVal = -1 - int'($random(seed) & 32'hffff); // negative, fits 19 bits
		y = $random(seed);
		loadReg(4'd5, y);
		irw = fieldWord(4'd5, 4'd0);
		irw[18:0] = cVal[18:0];
		loadIr(irw);
		xfer(sRa, dY);
		xfer(sConst, dZ, cpuPkg::opAdd);
		xfer(sZLow, dOut);
		checkWord("outPort(const)", outPort, y + cpuPkg::word_t'(cVal));
	endtask

	task automatic branchConditions();
		cpuPkg::word_t vals [3];
		cpuPkg::word_t irw, r0;
		cpuPkg::cond_t c;
		logic expBit;
		r0 = $random(seed) | 32'h1;
		loadReg(4'd0, r0);
		readReg(4'd0, r0); // plain rOut still sees r0
		loadIr(fieldWord(4'd0, 4'd0)); // condZero
		xfer(sBase, dOut);
		checkWord("outPort(baOut)", outPort, '0);
		xfer(sBase, dCon);
		checkBit("branchOut(baOut)", branchOut, 1'b1);
		vals[0] = '0;
		vals[1] = ($random(seed) & 32'h7fff_ffff) | 32'h1;
		vals[2] = $random(seed) | 32'h8000_0000;
		for (int ci = 0; ci < 4; ci++) begin
			c = cpuPkg::cond_t'(ci);
			for (int vi = 0; vi < 3; vi++) begin
				loadReg(4'd1, vals[vi]);
				irw = fieldWord(4'd1, 4'd0);
				irw[20:19] = c;
				loadIr(irw);
				xfer(sRa, dCon);
				case (c)
					cpuPkg::condZero: expBit = (vals[vi] == 32'd0);
					cpuPkg::condNonZero: expBit = (vals[vi] != 32'd0);
					cpuPkg::condPos: expBit = ~vals[vi][31];
					default: expBit = vals[vi][31];
				endcase
				checkBit($sformatf("branchOut(%s)", c.name()), branchOut, expBit);
			end
		end
	endtask

	initial begin
		inPortData = '0;
		clearStrobes();
		rstN = 1'b0;
		repeat (4) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
		checkWord("outPort(reset)", outPort, '0);
		regTransfer();
		aluOps();
		signedMultiply();
		memoryAccess();
		pcAndConst();
		branchConditions();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
